// File: body_integrator.sv
`timescale 1ns/1ns
`default_nettype none

module body_integrator
    import character_pkg::*;
(
    input  logic   character_clk,
    input  logic   sys_rst_n,
    motion_if.body cmd,
    motion_if.body contact,
    output phy_t   vel_x,
    output phy_t   vel_y,
    output phy_t   step_x,
    output phy_t   step_y
);

    phy_t vel_x_next;
    phy_t vel_y_next;
    phy_t walk_nudge;

    // ----------------------------------------
    // next velocity
    // ----------------------------------------
    always_comb begin
        vel_x_next = vel_x;
        vel_y_next = vel_y;
        if (cmd.launch) begin
            vel_x_next = cmd.launch_vel_x;
            vel_y_next = cmd.launch_vel_y;
        end else begin
            // horizontal: landing stops, walls reflect
            if (contact.landed) begin
                vel_x_next = '0;
            end else if (contact.hit_side) begin
                vel_x_next = -vel_x;
            end

            // vertical
            if (contact.landed || contact.hit_ceiling) begin
                vel_y_next = '0;
            end else if (!contact.on_ground) begin
                vel_y_next = vel_y + GRAVITY;
            end
        end
    end

    // one nudge per walk cycle, only meaningful on the ground
    assign walk_nudge = cmd.walk ? phy_t'(cmd.walk_dir) * WALK_STEP : '0;

    always_ff @(posedge character_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            vel_x <= '0;
            vel_y <= '0;
        end else begin
            vel_x <= vel_x_next;
            vel_y <= vel_y_next;
        end
    end

    // step follows the corrected velocity, so at most one stale step after a contact
    always_ff @(posedge character_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            step_x <= '0;
            step_y <= '0;
        end else begin
            step_x <= vel_x_next + walk_nudge;
            step_y <= vel_y_next;
        end
    end

endmodule

`default_nettype wire

// File: character_pkg.sv
`default_nettype none

package character_pkg;

    // physics number format
    localparam int PHY_WIDTH = 10;                  // top bit index, 11-bit values
    typedef logic signed [PHY_WIDTH:0] phy_t;

    // movement states
    typedef enum logic [2:0] {
        IDLE,
        LEFT,
        RIGHT,
        CHARGE,
        JUMP,
        AIRBORNE
    } move_state_t;

    // ----------------------------------------
    // map and character geometry
    // ----------------------------------------
    localparam int MAP_WIDTH_X  = 100;
    localparam int MAP_WIDTH_Y  = 100;
    localparam int MAP_X_OFFSET = 270;
    localparam int MAP_Y_OFFSET = 50;
    localparam int WALL_WIDTH   = 10;
    localparam int CHAR_WIDTH_X = 32;
    localparam int CHAR_WIDTH_Y = 32;

    // x is mirrored, so the left limit is the larger one
    localparam phy_t LEFT_LIMIT    = phy_t'(MAP_X_OFFSET + WALL_WIDTH
                                            + MAP_WIDTH_X - 2 * WALL_WIDTH - CHAR_WIDTH_X);
    localparam phy_t RIGHT_LIMIT   = phy_t'(MAP_X_OFFSET + WALL_WIDTH);
    localparam phy_t FLOOR_Y       = phy_t'(MAP_Y_OFFSET + WALL_WIDTH);
    localparam phy_t CEILING_Y     = phy_t'(MAP_Y_OFFSET + WALL_WIDTH
                                            + MAP_WIDTH_Y - 2 * WALL_WIDTH - CHAR_WIDTH_Y);
    localparam phy_t INITIAL_POS_X = phy_t'((MAP_X_OFFSET + WALL_WIDTH) * 2
                                            + MAP_WIDTH_X - 2 * WALL_WIDTH - CHAR_WIDTH_X) >>> 1;

    // ----------------------------------------
    // physics constants
    // ----------------------------------------
    localparam phy_t GRAVITY    = phy_t'(-1);
    localparam phy_t WALK_STEP  = phy_t'(1);
    localparam phy_t JUMP_VEL_X = phy_t'(4);
    localparam phy_t JUMP_VEL_Y = phy_t'(8);

    // jump charge counter
    localparam int CHARGE_WIDTH = 7;
    localparam logic [CHARGE_WIDTH-1:0] MAX_CHARGE       = CHARGE_WIDTH'(100);
    localparam logic [CHARGE_WIDTH-1:0] CHARGE_INCREMENT = CHARGE_WIDTH'(10);

endpackage

`default_nettype wire

// File: character_sva.sv
`timescale 1ns/1ns
`default_nettype none

module character_sva
    import character_pkg::*;
(
    input logic                    character_clk,
    input logic                    sys_rst_n,
    input logic                    left_btn,
    input logic                    right_btn,
    input move_state_t             state,
    input logic signed [1:0]       face,
    input logic [CHARGE_WIDTH-1:0] charge_cnt,
    input phy_t                    pos_x,
    input phy_t                    pos_y,
    input phy_t                    vel_x,
    input phy_t                    vel_y,
    input logic                    on_ground,
    input logic                    hit_side,
    input logic                    landed
);

    logic left_q;
    logic right_q;
    logic idle_q;
    logic left_start;
    logic right_start;
    int   fail_cnt = 0;

    // reference ceil log2, counts up until the power covers the value
    function automatic int ceil_log2_ref(input int value);
        int n;
        n = 0;
        while ((1 << n) < value) begin
            n++;
        end
        return n;
    endfunction

    always_ff @(posedge character_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            left_q  <= 1'b0;
            right_q <= 1'b0;
            idle_q  <= 1'b0;
        end else begin
            left_q  <= left_btn;
            right_q <= right_btn;
            idle_q  <= (state == IDLE);   // no nudge in flight
        end
    end

    assign left_start  = left_btn && !left_q && state == IDLE && idle_q && on_ground
                       && vel_x == 0 && pos_x < LEFT_LIMIT;
    assign right_start = right_btn && !right_q && !(left_btn && !left_q) && state == IDLE
                       && idle_q && on_ground && vel_x == 0 && pos_x > RIGHT_LIMIT;

    // ----------------------------------------
    a_reset: assert property (@(posedge character_clk) $rose(sys_rst_n) |->
        state == IDLE && pos_x == INITIAL_POS_X && pos_y == FLOOR_Y && vel_x == 0
        && vel_y == 0 && face == 2'sd1 && charge_cnt == 1 && on_ground)
        else begin
            $error("FAIL state %h pos_x %h pos_y %h vel_x %h vel_y %h face %h charge_cnt %h",
                   $sampled(state), $sampled(pos_x), $sampled(pos_y), $sampled(vel_x),
                   $sampled(vel_y), $sampled(face), $sampled(charge_cnt));
            fail_cnt++;
        end

    a_walk_left: assert property (@(posedge character_clk) disable iff (!sys_rst_n)
        $past(left_start, 3) |-> pos_x == $past(pos_x, 3) + WALK_STEP)
        else begin
            $error("FAIL pos_x %h after a left walk nudge", $sampled(pos_x));
            fail_cnt++;
        end

    a_walk_right: assert property (@(posedge character_clk) disable iff (!sys_rst_n)
        $past(right_start, 3) |-> pos_x == $past(pos_x, 3) - WALK_STEP)
        else begin
            $error("FAIL pos_x %h after a right walk nudge", $sampled(pos_x));
            fail_cnt++;
        end

    a_walk_still: assert property (@(posedge character_clk) disable iff (!sys_rst_n)
        state inside {LEFT, RIGHT} |-> vel_x == 0)
        else begin
            $error("FAIL vel_x %h during a walk, expected 0", $sampled(vel_x));
            fail_cnt++;
        end

    a_charge: assert property (@(posedge character_clk) disable iff (!sys_rst_n)
        state == CHARGE && charge_cnt < MAX_CHARGE |=>
        charge_cnt == $past(charge_cnt) + CHARGE_INCREMENT)
        else begin
            $error("FAIL charge_cnt %h while charging", $sampled(charge_cnt));
            fail_cnt++;
        end

    a_launch: assert property (@(posedge character_clk) disable iff (!sys_rst_n)
        state == JUMP |=>
        int'(vel_y) == int'(JUMP_VEL_Y) * ceil_log2_ref(int'($past(charge_cnt)))
        && int'(vel_x) == int'(JUMP_VEL_X) * ceil_log2_ref(int'($past(charge_cnt)))
           * int'($past(face)))
        else begin
            $error("FAIL vel_x %h vel_y %h after launch", $sampled(vel_x), $sampled(vel_y));
            fail_cnt++;
        end

    a_gravity: assert property (@(posedge character_clk) disable iff (!sys_rst_n)
        state == AIRBORNE && !on_ground && pos_y != CEILING_Y |=>
        vel_y == $past(vel_y) + GRAVITY)
        else begin
            $error("FAIL vel_y %h while airborne", $sampled(vel_y));
            fail_cnt++;
        end

    a_bounds: assert property (@(posedge character_clk) disable iff (!sys_rst_n)
        pos_x >= RIGHT_LIMIT && pos_x <= LEFT_LIMIT && pos_y >= FLOOR_Y && pos_y <= CEILING_Y)
        else begin
            $error("FAIL pos_x %h pos_y %h outside the map", $sampled(pos_x), $sampled(pos_y));
            fail_cnt++;
        end

    a_side: assert property (@(posedge character_clk) disable iff (!sys_rst_n)
        hit_side && !landed && state != JUMP |=>
        vel_x == -$past(vel_x) && face == -$past(face))
        else begin
            $error("FAIL vel_x %h face %h after a side hit", $sampled(vel_x), $sampled(face));
            fail_cnt++;
        end

    a_land: assert property (@(posedge character_clk) disable iff (!sys_rst_n)
        landed && state == AIRBORNE |=>
        state == IDLE && on_ground && vel_x == 0 && vel_y == 0)
        else begin
            $error("FAIL state %h vel_x %h vel_y %h after landing",
                   $sampled(state), $sampled(vel_x), $sampled(vel_y));
            fail_cnt++;
        end

endmodule

`default_nettype wire

// File: character_top.sv
`timescale 1ns/1ns
`default_nettype none

module character_top
    import character_pkg::*;
(
    input  logic                    character_clk,
    input  logic                    sys_rst_n,
    input  logic                    left_btn,
    input  logic                    right_btn,
    input  logic                    jump_btn,
    output phy_t                    pos_x,
    output phy_t                    pos_y,
    output phy_t                    vel_x,
    output phy_t                    vel_y,
    output logic signed [1:0]       face,
    output logic [CHARGE_WIDTH-1:0] charge_cnt,
    output move_state_t             state,
    output logic                    on_ground
);

    phy_t step_x;
    phy_t step_y;

    motion_if u_cmd_if ();        // jump_control to body_integrator
    motion_if u_contact_if ();    // wall_resolver back to both

    jump_control u_jump_control (
        .character_clk (character_clk),
        .sys_rst_n     (sys_rst_n),
        .left_btn      (left_btn),
        .right_btn     (right_btn),
        .jump_btn      (jump_btn),
        .cmd           (u_cmd_if.ctrl),
        .contact       (u_contact_if.ctrl),
        .state         (state),
        .face          (face),
        .charge_cnt    (charge_cnt)
    );

    body_integrator u_body_integrator (
        .character_clk (character_clk),
        .sys_rst_n     (sys_rst_n),
        .cmd           (u_cmd_if.body),
        .contact       (u_contact_if.body),
        .vel_x         (vel_x),
        .vel_y         (vel_y),
        .step_x        (step_x),
        .step_y        (step_y)
    );

    wall_resolver u_wall_resolver (
        .character_clk (character_clk),
        .sys_rst_n     (sys_rst_n),
        .step_x        (step_x),
        .step_y        (step_y),
        .contact       (u_contact_if.resolver),
        .pos_x         (pos_x),
        .pos_y         (pos_y)
    );

    assign on_ground = u_contact_if.on_ground;

endmodule

`default_nettype wire

// File: filelist.f
character_pkg.sv
motion_if.sv
jump_control.sv
body_integrator.sv
wall_resolver.sv
character_top.sv
character_sva.sv
tb_character.sv

// File: jump_control.sv
`timescale 1ns/1ns
`default_nettype none

module jump_control
    import character_pkg::*;
(
    input  logic                    character_clk,
    input  logic                    sys_rst_n,
    input  logic                    left_btn,
    input  logic                    right_btn,
    input  logic                    jump_btn,
    motion_if.ctrl                  cmd,
    motion_if.ctrl                  contact,
    output move_state_t             state,
    output logic signed [1:0]       face,        // +1 left, -1 right
    output logic [CHARGE_WIDTH-1:0] charge_cnt
);

    logic        left_btn_d;
    logic        right_btn_d;
    logic        jump_btn_d;
    logic        left_rise;
    logic        right_rise;
    logic        jump_rise;
    move_state_t next_state;
    phy_t        log_cnt;

    // smallest n with 2**n >= value
    function automatic phy_t ceil_log2(input logic [CHARGE_WIDTH-1:0] value);
        logic [CHARGE_WIDTH-1:0] below;
        phy_t                    result;
        below  = value - 1'b1;
        result = '0;
        for (int i = 0; i < CHARGE_WIDTH; i++) begin
            if (below[i]) begin
                result = phy_t'(i + 1);
            end
        end
        return result;
    endfunction

    // ----------------------------------------
    // button edges
    // ----------------------------------------
    always_ff @(posedge character_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            left_btn_d  <= 1'b0;
            right_btn_d <= 1'b0;
            jump_btn_d  <= 1'b0;
        end else begin
            left_btn_d  <= left_btn;
            right_btn_d <= right_btn;
            jump_btn_d  <= jump_btn;
        end
    end

    assign left_rise  = left_btn & ~left_btn_d;
    assign right_rise = right_btn & ~right_btn_d;
    assign jump_rise  = jump_btn & ~jump_btn_d;

    // ----------------------------------------
    // movement FSM
    // ----------------------------------------
    always_comb begin
        next_state = IDLE;
        case (state)
            IDLE, LEFT, RIGHT: begin
                if (contact.on_ground) begin
                    if (left_rise) begin          // left wins over right and jump
                        next_state = LEFT;
                    end else if (right_rise) begin
                        next_state = RIGHT;
                    end else if (jump_rise) begin
                        next_state = CHARGE;
                    end
                end
            end
            CHARGE: begin
                if (charge_cnt >= MAX_CHARGE || !jump_btn) begin
                    next_state = JUMP;
                end else begin
                    next_state = CHARGE;
                end
            end
            JUMP:     next_state = AIRBORNE;
            AIRBORNE: next_state = contact.landed ? IDLE : AIRBORNE;
            default:  next_state = IDLE;
        endcase
    end

    always_ff @(posedge character_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // charge saturates once the limit is reached
    always_ff @(posedge character_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            charge_cnt <= CHARGE_WIDTH'(1);
        end else if (state == CHARGE && charge_cnt < MAX_CHARGE) begin
            charge_cnt <= charge_cnt + CHARGE_INCREMENT;
        end else if (state == JUMP) begin
            charge_cnt <= CHARGE_WIDTH'(1);
        end
    end

    always_ff @(posedge character_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            face <= 2'sd1;
        end else if (contact.hit_side) begin
            face <= -face;                        // bounced off a wall
        end else if (state == LEFT) begin
            face <= 2'sd1;
        end else if (state == RIGHT) begin
            face <= -2'sd1;
        end
    end

    // ----------------------------------------
    // commands to the integrator
    // ----------------------------------------
    assign log_cnt = ceil_log2(charge_cnt);

    assign cmd.walk         = (state == LEFT) || (state == RIGHT);
    assign cmd.walk_dir     = (state == LEFT) ? 2'sd1 : ((state == RIGHT) ? -2'sd1 : 2'sd0);
    assign cmd.launch       = (state == JUMP);
    assign cmd.launch_vel_x = JUMP_VEL_X * log_cnt * phy_t'(face);
    assign cmd.launch_vel_y = JUMP_VEL_Y * log_cnt;

endmodule

`default_nettype wire

// File: motion_if.sv
`timescale 1ns/1ns
`default_nettype none

interface motion_if
    import character_pkg::*;
();

    // commands from jump_control
    logic              walk;          // level, high in LEFT or RIGHT
    logic signed [1:0] walk_dir;      // +1 left, -1 right
    logic              launch;        // level, high in JUMP
    phy_t              launch_vel_x;
    phy_t              launch_vel_y;

    // contact events from wall_resolver
    logic hit_side;                   // one-cycle pulses
    logic hit_ceiling;
    logic landed;
    logic on_ground;                  // level

    modport ctrl (
        output walk, walk_dir, launch, launch_vel_x, launch_vel_y,
        input  hit_side, hit_ceiling, landed, on_ground
    );

    modport body (
        input walk, walk_dir, launch, launch_vel_x, launch_vel_y,
        input hit_side, hit_ceiling, landed, on_ground
    );

    modport resolver (
        output hit_side, hit_ceiling, landed, on_ground
    );

endinterface

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_character -f filelist.f

# an assertion failure stops the run, the log decides
./obj_dir/Vtb_character > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with no errors" sim.log; then
    exit 0
else
    exit 1
fi

// File: tb_character.sv
`timescale 1ns/1ns
`default_nettype none

module tb_character
    import character_pkg::*;
();

    logic                    character_clk;
    logic                    sys_rst_n;
    logic                    left_btn;
    logic                    right_btn;
    logic                    jump_btn;
    phy_t                    pos_x;
    phy_t                    pos_y;
    phy_t                    vel_x;
    phy_t                    vel_y;
    logic signed [1:0]       face;
    logic [CHARGE_WIDTH-1:0] charge_cnt;
    move_state_t             state;
    logic                    on_ground;
    int                      tests;
    int                      failed_tests;
    int                      failures;
    int                      errs;

    character_top u_character_top (.*);

    bind character_top character_sva u_character_sva (
        .*,
        .hit_side (u_contact_if.hit_side),
        .landed   (u_contact_if.landed)
    );

    initial begin
        character_clk = 1'b0;
        forever #5 character_clk = ~character_clk;
    end

    // ----------------------------------------
    // timeouts here plus failed assertions in the checker
    function automatic int error_count();
        return failures + u_character_top.u_character_sva.fail_cnt;
    endfunction

    task automatic wait_for_state(input move_state_t target, input int limit);
        int n;
        n = 0;
        while (state != target && n < limit) begin
            @(negedge character_clk);
            n++;
        end
        if (state != target) begin
            failures++;
            $display("timed out waiting for state %s", target.name());
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        if (error_count() == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: failed", name);
        end
    endtask

    task automatic walk(input bit go_left);
        int hold;
        hold = 1 + ($urandom % 3);
        @(negedge character_clk);
        if (go_left) begin
            left_btn = 1'b1;
        end else begin
            right_btn = 1'b1;
        end
        repeat (hold) @(negedge character_clk);
        left_btn  = 1'b0;
        right_btn = 1'b0;
        repeat (6) @(negedge character_clk);       // let the nudge settle
    endtask

    // hold 0 means a full charge
    task automatic jump(input int hold);
        @(negedge character_clk);
        jump_btn = 1'b1;
        if (hold > 0) begin
            repeat (hold) @(negedge character_clk);
        end else begin
            wait_for_state(JUMP, 40);
        end
        jump_btn = 1'b0;
        wait_for_state(AIRBORNE, 40);
        wait_for_state(IDLE, 2000);
        repeat (8) @(negedge character_clk);
    endtask

    // ----------------------------------------
    initial begin
        void'($urandom(83));
        sys_rst_n    = 1'b0;
        left_btn     = 1'b0;
        right_btn    = 1'b0;
        jump_btn     = 1'b0;
        tests        = 0;
        failed_tests = 0;
        failures     = 0;
        repeat (8) @(posedge character_clk);
        @(negedge character_clk);
        sys_rst_n = 1'b1;
        repeat (4) @(negedge character_clk);
        finish_test("reset", 0);

        errs = error_count();
        repeat (30) walk(1'b1);                       // runs into the left wall
        finish_test("walk left", errs);
        errs = error_count();
        repeat (30) walk(1'b0);
        finish_test("walk right", errs);

        errs = error_count();
        jump(1 + ($urandom % 8));                     // facing right
        walk(1'b1);
        jump(1 + ($urandom % 8));
        finish_test("random charge jumps", errs);
        errs = error_count();
        jump(0);
        finish_test("full charge jump", errs);

        $display("tests: %0d, failed: %0d, errors: %0d", tests, failed_tests, error_count());
        if (error_count() == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: wall_resolver.sv
`timescale 1ns/1ns
`default_nettype none

module wall_resolver
    import character_pkg::*;
(
    input  logic       character_clk,
    input  logic       sys_rst_n,
    input  phy_t       step_x,
    input  phy_t       step_y,
    motion_if.resolver contact,
    output phy_t       pos_x,
    output phy_t       pos_y
);

    phy_t sum_x;
    phy_t sum_y;
    phy_t clamp_x;
    phy_t clamp_y;
    logic left_hit;
    logic right_hit;
    logic floor_hit;
    logic ceiling_hit;

    // ----------------------------------------
    // step and clamp
    // ----------------------------------------
    assign sum_x = pos_x + step_x;
    assign sum_y = pos_y + step_y;

    assign left_hit    = (sum_x > LEFT_LIMIT);            // left grows x
    assign right_hit   = (sum_x < RIGHT_LIMIT);
    assign floor_hit   = (sum_y <= FLOOR_Y) && (step_y < 0);
    assign ceiling_hit = (sum_y >= CEILING_Y) && (step_y > 0);

    always_comb begin
        clamp_x = sum_x;
        if (left_hit) begin
            clamp_x = LEFT_LIMIT;
        end else if (right_hit) begin
            clamp_x = RIGHT_LIMIT;
        end
    end

    always_comb begin
        clamp_y = sum_y;
        if (floor_hit) begin
            clamp_y = FLOOR_Y;
        end else if (ceiling_hit) begin
            clamp_y = CEILING_Y;
        end
    end

    always_ff @(posedge character_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            pos_x <= INITIAL_POS_X;
            pos_y <= FLOOR_Y;
        end else begin
            pos_x <= clamp_x;
            pos_y <= clamp_y;
        end
    end

    // ----------------------------------------
    // contact reporting
    // ----------------------------------------
    // a clamp at a limit already touched is a stale step, no new pulse
    always_ff @(posedge character_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            contact.hit_side    <= 1'b0;
            contact.hit_ceiling <= 1'b0;
            contact.landed      <= 1'b0;
        end else begin
            contact.hit_side    <= (left_hit && pos_x != LEFT_LIMIT)
                                || (right_hit && pos_x != RIGHT_LIMIT);
            contact.hit_ceiling <= ceiling_hit && (pos_y != CEILING_Y);
            contact.landed      <= floor_hit && (pos_y != FLOOR_Y);   // was airborne
        end
    end

    assign contact.on_ground = (pos_y == FLOOR_Y);

endmodule

`default_nettype wire
